// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_dedisp
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/dedisp_pkg.sv ====
//******************************
// dedispersion shared definitions
// channel count, per-channel delays, widths
// and the stream word types
//******************************
package dedisp_pkg;

    // fft channels per frame, keep a power of two
    localparam int n_channels = 8;
    localparam int chan_w = $clog2(n_channels);

    // signed real and imaginary parts
    localparam int bin_w = 16;
    // re^2 + im^2 always fits unsigned in 2*bin_w
    localparam int pwr_w = 2 * bin_w;
    // room for n_channels powers added together
    localparam int sum_w = pwr_w + chan_w;

    // delay in frames per channel, index is the channel number
    // highest channel arrives first, so it waits the least
    localparam int delay_table [n_channels] = '{9, 8, 7, 6, 5, 4, 3, 2};

    function automatic int table_max();
        int m;
        m = 0;
        for (int i = 0; i < n_channels; i++) begin
            if (delay_table[i] > m) begin
                m = delay_table[i];
            end
        end
        return m;
    endfunction

    // deepest line, sets buffer clear time
    localparam int max_delay = table_max();

    typedef struct packed {
        logic signed [bin_w-1:0] re;
        logic signed [bin_w-1:0] im;
        logic                    valid;
    } fft_bin_t;

    // sof on channel 0, eof on the last channel
    typedef struct packed {
        logic [pwr_w-1:0] data;
        logic             valid;
        logic             sof;
        logic             eof;
    } pwr_sample_t;

    typedef struct packed {
        logic [sum_w-1:0] data;
        logic             valid;
    } sum_sample_t;

endpackage

// ==== dedispersor/dedispersor.sv ====
//******************************
// serial dedispersor
// steers each channel into its own
// delay line, frames the output
//******************************
module dedispersor import dedisp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pwr_sample_t pwr,
    output pwr_sample_t dedisp_out
);

    logic [chan_w-1:0]   chan_cnt;
    logic [n_channels-1:0] blk_valid;
    logic [pwr_w-1:0]    blk_dout [n_channels];
    logic [n_channels-1:0] blk_dout_valid;
    logic [pwr_w-1:0]    sel_data;
    logic                sel_valid;
    logic                sof_d;
    logic                eof_d;

    // channel position within the frame, wraps every n_channels words
    always_ff @(posedge clk) begin
        if (rst) begin
            chan_cnt <= '0;
        end else if (pwr.valid) begin
            chan_cnt <= chan_cnt + 1'b1;
        end
    end

    // markers delayed by one, lined up with block outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            sof_d <= 1'b0;
            eof_d <= 1'b0;
        end else begin
            sof_d <= pwr.valid && (chan_cnt == '0);
            eof_d <= pwr.valid && (chan_cnt == chan_w'(n_channels - 1));
        end
    end

    for (genvar k = 0; k < n_channels; k++) begin : g_chan
        // only the current channel's line sees the write
        assign blk_valid[k] = pwr.valid && (chan_cnt == chan_w'(k));

        dedispersor_block #(
            .delay(delay_table[k])
        ) u_block (
            .clk        (clk),
            .rst        (rst),
            .din        (pwr.data),
            .din_valid  (blk_valid[k]),
            .dout       (blk_dout[k]),
            .dout_valid (blk_dout_valid[k])
        );
    end

    // at most one block answers per cycle
    always_comb begin
        sel_data = '0;
        for (int k = 0; k < n_channels; k++) begin
            if (blk_dout_valid[k]) begin
                sel_data = blk_dout[k];
            end
        end
    end

    assign sel_valid = |blk_dout_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dedisp_out.valid <= 1'b0;
            dedisp_out.sof   <= 1'b0;
            dedisp_out.eof   <= 1'b0;
        end else begin
            dedisp_out.valid <= sel_valid;
            // no marker without a word behind it
            dedisp_out.sof   <= sof_d && sel_valid;
            dedisp_out.eof   <= eof_d && sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            dedisp_out.data <= sel_data;
        end
    end

endmodule

// ==== dedispersor/dedispersor_block.sv ====
//******************************
// dedispersor delay line
// circular buffer returning the word
// written a fixed number of writes ago
//******************************
module dedispersor_block import dedisp_pkg::*; #(
    parameter int delay = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [pwr_w-1:0] din,
    input  logic             din_valid,
    output logic [pwr_w-1:0] dout,
    output logic             dout_valid
);

    // a 1-deep line still needs one pointer bit
    localparam int ptr_w = (delay > 1) ? $clog2(delay) : 1;
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(delay - 1);

    logic [pwr_w-1:0] mem [delay];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] clear_cnt;
    logic             clearing;
    logic             wr_en;

    // writes held off until every entry is zero
    assign wr_en = din_valid && !clearing;

    always_ff @(posedge clk) begin
        if (rst) begin
            clearing   <= 1'b1;
            clear_cnt  <= '0;
            wr_ptr     <= '0;
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= wr_en;
            if (clearing) begin
                clear_cnt <= clear_cnt + 1'b1;
                // one entry per cycle, done after the last one
                if (clear_cnt == last_idx) begin
                    clearing <= 1'b0;
                end
            end else if (wr_en) begin
                // oldest entry goes out before being replaced
                dout   <= mem[wr_ptr];
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clear_cnt] <= '0;
        end else if (din_valid) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+tests
common/dedisp_pkg.sv
dedispersor/dedispersor_block.sv
dedispersor/dedispersor.sv
logic/power_detector.sv
logic/channel_summer.sv
logic/dedisp_top.sv
tests/tb_dedisp.sv

// ==== logic/channel_summer.sv ====
//******************************
// channel summer
// adds the aligned channels of a frame
// into one time-series sample
//******************************
module channel_summer import dedisp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pwr_sample_t dedisp_out,
    output sum_sample_t series_out
);

    logic [sum_w-1:0] acc;
    logic [sum_w-1:0] frame_sum;
    logic [sum_w-1:0] series_data;
    logic             series_valid;

    // sof restarts the sum and other words add on
    always_comb begin
        if (dedisp_out.sof) begin
            frame_sum = sum_w'(dedisp_out.data);
        end else begin
            frame_sum = acc + sum_w'(dedisp_out.data);
        end
    end

    // running sum of the current frame
    always_ff @(posedge clk) begin
        if (dedisp_out.valid) begin
            acc <= frame_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            series_valid <= 1'b0;
        end else begin
            // one pulse per frame on the last channel
            series_valid <= dedisp_out.valid && dedisp_out.eof;
        end
    end

    always_ff @(posedge clk) begin
        if (dedisp_out.valid && dedisp_out.eof) begin
            series_data <= frame_sum;
        end
    end

    assign series_out.data  = series_data;
    assign series_out.valid = series_valid;

endmodule

// ==== logic/dedisp_top.sv ====
//******************************
// dedispersion top
// power detect, dedisperse, sum
//******************************
module dedisp_top import dedisp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fft_bin_t    bin_in,
    output pwr_sample_t dedisp_out,
    output sum_sample_t series_out
);

    // power stream, unframed
    pwr_sample_t pwr;

    power_detector u_power_detector (
        .clk    (clk),
        .rst    (rst),
        .bin_in (bin_in),
        .pwr    (pwr)
    );

    // delayed and framed, 2 cycles after pwr
    dedispersor u_dedispersor (
        .clk        (clk),
        .rst        (rst),
        .pwr        (pwr),
        .dedisp_out (dedisp_out)
    );

    // one sample per frame
    channel_summer u_channel_summer (
        .clk        (clk),
        .rst        (rst),
        .dedisp_out (dedisp_out),
        .series_out (series_out)
    );

endmodule

// ==== logic/power_detector.sv ====
//******************************
// power detector
// registered re^2 + im^2 for each fft bin
//******************************
module power_detector import dedisp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fft_bin_t    bin_in,
    output pwr_sample_t pwr
);

    logic signed [pwr_w-1:0] re_sq;
    logic signed [pwr_w-1:0] im_sq;
    logic [pwr_w-1:0]        pwr_data;
    logic                    pwr_valid;

    // full-width signed products
    assign re_sq = pwr_w'(bin_in.re) * pwr_w'(bin_in.re);
    assign im_sq = pwr_w'(bin_in.im) * pwr_w'(bin_in.im);

    always_ff @(posedge clk) begin
        if (rst) begin
            pwr_valid <= 1'b0;
        end else begin
            pwr_valid <= bin_in.valid;
        end
    end

    // sum reaches 2^31 so it is kept unsigned
    always_ff @(posedge clk) begin
        if (bin_in.valid) begin
            pwr_data <= pwr_w'(unsigned'(re_sq)) + pwr_w'(unsigned'(im_sq));
        end
    end

    assign pwr.data  = pwr_data;
    assign pwr.valid = pwr_valid;
    // framing is added later in the dedispersor
    assign pwr.sof   = 1'b0;
    assign pwr.eof   = 1'b0;

endmodule

// ==== tests/dedisp_model.svh ====
//******************************
// dedispersion reference model
// power, channel history and frame sums
// worked out from the accepted input bins
//******************************
`ifndef DEDISP_MODEL_SVH
`define DEDISP_MODEL_SVH

// every valid bin since the last reset, oldest first
fft_bin_t model_bins [$];

task automatic model_reset();
    model_bins.delete();
endtask

task automatic model_push(input fft_bin_t b);
    model_bins.push_back(b);
endtask

// re^2 + im^2 in 64 bits, nothing can wrap
function automatic logic [pwr_w-1:0] ref_power(input fft_bin_t b);
    longint re;
    longint im;
    re = longint'($signed(b.re));
    im = longint'($signed(b.im));
    return pwr_w'(re * re + im * im);
endfunction

// stream word idx is channel idx % n_channels of frame idx / n_channels
// and carries that channel's power from delay_table frames back
function automatic logic [pwr_w-1:0] ref_history(input int idx);
    int chan;
    int frame;
    int back;
    chan  = idx % n_channels;
    frame = idx / n_channels;
    back  = delay_table[chan];
    // channel not yet seen that many frames since reset
    if (frame < back) begin
        return '0;
    end
    return ref_power(model_bins[idx - back * n_channels]);
endfunction

// all dedispersed words of one frame added up
function automatic logic [sum_w-1:0] ref_frame_sum(input int frame);
    longint total;
    total = 0;
    for (int k = 0; k < n_channels; k++) begin
        total += longint'(ref_history(frame * n_channels + k));
    end
    return sum_w'(total);
endfunction

`endif

// ==== tests/tb_dedisp.sv ====
//******************************
// dedispersion testbench
// random bins with gaps, mid-stream reset
// and a dispersed pulse, checked in order
//******************************
module tb_dedisp import dedisp_pkg::*; ();

    localparam int clk_period     = 4;
    localparam int random_frames  = 40;
    localparam int restart_frames = 12;
    localparam int pulse_frames   = max_delay + 4;
    // output frame where the pulse lines up
    localparam int pulse_frame    = max_delay + 2;
    localparam int frames_total   = random_frames + restart_frames + pulse_frames + 1;
    // three resets with clear time, plus drain slack
    localparam int reset_time     = 3 * (2 + max_delay + 8) * clk_period;
    localparam int watchdog_limit = frames_total * n_channels * clk_period * 3 + reset_time;
    localparam logic signed [bin_w-1:0] pulse_amp = 16'sh7fff;
    // every channel at full pulse power in one frame
    localparam longint pulse_sum = longint'(n_channels) * 2 * 32767 * 32767;

    logic        clk;
    logic        rst;
    fft_bin_t    bin_in;
    pwr_sample_t dedisp_out;
    sum_sample_t series_out;

    integer      seed;
    string       test_name;
    bit          count_pulse;
    int          pulse_hits;
    pwr_sample_t exp_pwr [$];
    sum_sample_t exp_sum [$];
    pwr_sample_t want_pwr;
    sum_sample_t want_sum;

    `include "dedisp_model.svh"

    dedisp_top u_dedisp_top (
        .clk        (clk),
        .rst        (rst),
        .bin_in     (bin_in),
        .dedisp_out (dedisp_out),
        .series_out (series_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_limit);
        $display("timeout, outputs stopped arriving at time %0t", $time);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        bin_in.valid = 1'b0;
    endtask

    // random gap cycles first, then one valid bin
    task automatic send_bin(input logic signed [bin_w-1:0] re,
                            input logic signed [bin_w-1:0] im);
        while (($random(seed) & 3) == 0) begin
            idle_cycle();
        end
        @(posedge clk);
        #1;
        bin_in.re    = re;
        bin_in.im    = im;
        bin_in.valid = 1'b1;
    endtask

    task automatic send_random(input int words);
        for (int i = 0; i < words; i++) begin
            send_bin(bin_w'($random(seed)), bin_w'($random(seed)));
        end
    endtask

    // channel k fires delay_table[k] frames ahead of pulse_frame
    task automatic send_pulse();
        for (int f = 0; f < pulse_frames; f++) begin
            for (int k = 0; k < n_channels; k++) begin
                if (f == pulse_frame - delay_table[k]) begin
                    send_bin(pulse_amp, pulse_amp);
                end else begin
                    send_bin('0, '0);
                end
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst    = 1'b1;
        bin_in = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // delay lines clear one entry per cycle
        repeat (max_delay) @(posedge clk);
    endtask

    task automatic drain_outputs();
        idle_cycle();
        while (exp_pwr.size() != 0 || exp_sum.size() != 0) begin
            @(posedge clk);
        end
        // quiet cycles catch stray words
        repeat (4) @(posedge clk);
    endtask

    task automatic expect_outputs(input fft_bin_t b);
        pwr_sample_t ep;
        sum_sample_t es;
        int idx;
        int chan;
        model_push(b);
        idx      = model_bins.size() - 1;
        chan     = idx % n_channels;
        ep.data  = ref_history(idx);
        ep.valid = 1'b1;
        ep.sof   = (chan == 0);
        ep.eof   = (chan == n_channels - 1);
        exp_pwr.push_back(ep);
        // frame complete, one sum due
        if (chan == n_channels - 1) begin
            es.data  = ref_frame_sum(idx / n_channels);
            es.valid = 1'b1;
            exp_sum.push_back(es);
        end
    endtask

    task automatic compare_pwr(input string name, input pwr_sample_t want,
                               input pwr_sample_t got);
        if (got !== want) begin
            $write("FAIL %s: dedisp_out expected data=%0d sof=%0b eof=%0b",
                   name, want.data, want.sof, want.eof);
            $display(", actual data=%0d sof=%0b eof=%0b", got.data, got.sof, got.eof);
            $display("Regression failed");
            $fatal(1, "dedisp_out mismatch");
        end
    endtask

    task automatic compare_sum(input string name, input sum_sample_t want,
                               input sum_sample_t got);
        if (got !== want) begin
            $display("FAIL %s: series_out expected %0d, actual %0d",
                     name, want.data, got.data);
            $display("Regression failed");
            $fatal(1, "series_out mismatch");
        end
    endtask

    task automatic report_stray(input string what);
        $display("%s arrived with no input behind it at time %0t", what, $time);
        $display("Regression failed");
        $fatal(1, "unexpected output");
    endtask

    // model follows the accepted inputs, restarts on reset
    always @(posedge clk) begin
        if (rst) begin
            model_reset();
            exp_pwr.delete();
            exp_sum.delete();
        end else if (bin_in.valid) begin
            expect_outputs(bin_in);
        end
    end

    // outputs settled by the falling edge
    always @(negedge clk) begin
        if (!rst && dedisp_out.valid === 1'b1) begin
            if (exp_pwr.size() == 0) begin
                report_stray("dedisp_out word");
            end else begin
                want_pwr = exp_pwr.pop_front();
                compare_pwr(test_name, want_pwr, dedisp_out);
            end
        end
        if (!rst && series_out.valid === 1'b1) begin
            if (exp_sum.size() == 0) begin
                report_stray("series_out sample");
            end else begin
                want_sum = exp_sum.pop_front();
                compare_sum(test_name, want_sum, series_out);
                if (count_pulse && longint'(series_out.data) >= pulse_sum) begin
                    pulse_hits++;
                end
            end
        end
    end

    initial begin
        seed        = 32'h3af0;
        rst         = 1'b1;
        bin_in      = '0;
        test_name   = "reset";
        count_pulse = 1'b0;
        pulse_hits  = 0;
        apply_reset();

        // long run, stops part way into a frame
        test_name = "random_stream";
        send_random(random_frames * n_channels + 3);
        // words still in flight get dropped
        apply_reset();

        test_name = "reset_restart";
        send_random(restart_frames * n_channels);
        drain_outputs();
        apply_reset();

        test_name   = "dispersed_pulse";
        count_pulse = 1'b1;
        send_pulse();
        drain_outputs();

        if (pulse_hits == 1) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("dispersed pulse gave %0d large frame sums, one expected", pulse_hits);
            $display("Regression failed");
            $fatal(1, "pulse check");
        end
    end

endmodule
